// ==== src/ikari_pkg.sv ====
// ------------------------------
// Shared constants and types for the dual Z80 bus glue
// Referenced by scoped name from the RTL files
// ------------------------------
`default_nettype none

package ikari_pkg;

    localparam int BYTE_W = 8;
    localparam int ADDR_W = 16;
    localparam int VA_W   = 12;

    localparam logic [BYTE_W-1:0] IDLE_BYTE = 8'hFF;   // Undriven bus

    // Upper address bits [15:11]
    localparam logic [4:0] IO_PAGE  = 5'h18;   // C000-C7FF
    localparam logic [4:0] VID_PAGE = 5'h19;   // C800-CFFF

    // I/O page index, address bits 10:8
    localparam logic [2:0] PORT_COIN  = 3'd0;
    localparam logic [2:0] PORT_P1    = 3'd1;
    localparam logic [2:0] PORT_P2    = 3'd2;
    localparam logic [2:0] PORT_BTN   = 3'd3;
    localparam logic [2:0] PORT_MCODE = 3'd4;
    localparam logic [2:0] PORT_DIP1  = 3'd5;
    localparam logic [2:0] PORT_DIP2  = 3'd6;
    localparam logic [2:0] PORT_NMI   = 3'd7;   // Mailbox control

    localparam logic [7:0] GAME_IKARIA = 8'h06;
    localparam logic [7:0] GAME_RAMBO3 = 8'h08;
    localparam logic [7:0] GAME_BTN_A  = 8'h05;   // Games with a button port
    localparam logic [7:0] GAME_BTN_B  = 8'h06;
    localparam logic [7:0] GAME_BTN_C  = 8'h10;
    localparam logic [7:0] GAME_BTN_D  = 8'h11;

    // Bit positions in the 16-bit player words, all active low
    localparam int BIT_COIN    = 0;
    localparam int BIT_START   = 1;
    localparam int BIT_BTN1    = 2;
    localparam int BIT_BTN2    = 3;
    localparam int BIT_ROT     = 4;   // Rotary, 4 bits up from here
    localparam int BIT_SERVICE = 9;
    localparam int BIT_LEFT    = 10;
    localparam int BIT_RIGHT   = 11;
    localparam int BIT_DOWN    = 12;
    localparam int BIT_UP      = 13;

    typedef struct packed {
        logic       start1, start2, coin1, coin2;
        logic [1:0] unused;
        logic       service, snd_busy;
    } sys_std_t;

    typedef struct packed {
        logic test, unused, snd_busy, start2, start1, service, coin2, coin1;
    } sys_jp_t;

    // System port byte, layout depends on the board revision
    typedef union packed {
        sys_std_t standard;
        sys_jp_t  ikari_jp;
    } sys_port_t;

endpackage

`default_nettype wire

// ==== src/cpu_bus_if.sv ====
// ------------------------------
// One Z80 bus as seen by the glue logic
// Driven at the top level, sampled by every block
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;

    logic [ikari_pkg::ADDR_W-1:0] addr;
    logic                         mreq_n;
    logic                         iorq_n;
    logic                         rd_n;
    logic                         wr_n;
    logic [ikari_pkg::BYTE_W-1:0] dout;   // CPU write data

    modport cpu  (output addr, mreq_n, iorq_n, rd_n, wr_n, dout);
    modport sink (input  addr, mreq_n, iorq_n, rd_n, wr_n, dout);

endinterface

`default_nettype wire

// ==== src/map_sel_if.sv ====
// ------------------------------
// Decoded selects of both memory maps
// bus_decoder drives, one modport per user
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface map_sel_if;

    logic [7:0] port_sel_n;   // CPU A I/O page strobes, by index
    logic       ctl_b_n;      // CPU B control page C000
    logic       acc_a_n;      // CPU A in C000-FFFF
    logic       vid_a_n;      // Video window terms, delayed address
    logic       vid_b_n;

    modport decoder (output port_sel_n, ctl_b_n, acc_a_n, vid_a_n, vid_b_n);
    modport reader  (input  port_sel_n, vid_a_n, vid_b_n);
    modport irq     (input  port_sel_n, ctl_b_n);
    modport data    (input  acc_a_n, vid_a_n, vid_b_n);

endinterface

`default_nettype wire

// ==== src/bus_decoder.sv ====
// ------------------------------
// Memory and I/O map decode of both CPUs
// Window terms use address bits 13:11 one clock late
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  logic     clk,
    cpu_bus_if.sink  cpu_a,
    cpu_bus_if.sink  cpu_b,
    map_sel_if.decoder sel,
    output logic     ae,
    output logic     be
);

    logic       a_creg, b_creg;     // C000-FFFF
    logic       a_io;               // CPU A I/O page access
    logic [2:0] a_hi_r, b_hi_r;     // Delayed address 13:11
    logic       a_vid_n, b_vid_n;

    assign a_creg = cpu_a.addr[15:14] == ikari_pkg::IO_PAGE[4:3];
    assign b_creg = cpu_b.addr[15:14] == ikari_pkg::IO_PAGE[4:3];

    // ------------------------------
    // I/O and control pages
    // ------------------------------
    assign a_io = !cpu_a.mreq_n && cpu_a.addr[15:11] == ikari_pkg::IO_PAGE;

    // One strobe per index, 74138 style
    assign sel.port_sel_n = ~({8{a_io}} & (8'b1 << cpu_a.addr[10:8]));

    // CPU B has a single control port at C000
    assign sel.ctl_b_n = !(!cpu_b.mreq_n && cpu_b.addr[15:11] == ikari_pkg::IO_PAGE);

    assign sel.acc_a_n = cpu_a.mreq_n || !a_creg;

    // ------------------------------
    // Video window C800-CFFF
    // ------------------------------
    always_ff @(posedge clk) begin
        a_hi_r <= cpu_a.addr[13:11];
        b_hi_r <= cpu_b.addr[13:11];
    end

    assign a_vid_n = !(a_creg && a_hi_r == ikari_pkg::VID_PAGE[2:0]);
    assign b_vid_n = !(b_creg && b_hi_r == ikari_pkg::VID_PAGE[2:0]);

    assign sel.vid_a_n = a_vid_n;
    assign sel.vid_b_n = b_vid_n;

    assign ae = !a_vid_n && !cpu_a.mreq_n;   // CPU A owns the video bus
    assign be = !b_vid_n && !cpu_b.mreq_n;

endmodule

`default_nettype wire

// ==== src/cpu_interrupts.sv ====
// ------------------------------
// Inter-CPU NMI mailbox and vertical blank interrupts
// Four edge-set flops, clear wins over set
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_interrupts (
    input  logic    clk,
    input  logic    RESETn,
    cpu_bus_if.sink cpu_a,
    cpu_bus_if.sink cpu_b,
    map_sel_if.irq  sel,
    input  logic    vbl,
    output logic    a_nmi_n,
    output logic    b_nmi_n,
    output logic    a_int_n,
    output logic    b_int_n
);

    // Flop order: A NMI, B NMI, A INT, B INT
    logic [3:0] trig;     // Set on rising edge
    logic [3:0] clr;      // Level clear
    logic [3:0] trig_r;
    logic [3:0] pend;     // Request pending

    logic a_ctl_n;        // C700 page of CPU A

    assign a_ctl_n = sel.port_sel_n[ikari_pkg::PORT_NMI];

    // Trigger rises when the read of the partner's control port ends
    assign trig[0] = sel.ctl_b_n | cpu_b.rd_n;
    assign trig[1] = a_ctl_n | cpu_a.rd_n;
    assign trig[2] = vbl;
    assign trig[3] = vbl;

    // Own write to the control port acks the NMI
    assign clr[0] = !a_ctl_n && !cpu_a.wr_n;
    assign clr[1] = !sel.ctl_b_n && !cpu_b.wr_n;
    assign clr[2] = !cpu_a.iorq_n;   // Interrupt acknowledge cycle
    assign clr[3] = !cpu_b.iorq_n;

    always_ff @(posedge clk) begin
        trig_r <= trig;   // Edge reference
        if (!RESETn) begin
            pend <= '0;
        end else begin
            pend <= (pend | (trig & ~trig_r)) & ~clr;
        end
    end

    assign a_nmi_n = ~pend[0];
    assign b_nmi_n = ~pend[1];
    assign a_int_n = ~pend[2];
    assign b_int_n = ~pend[3];

endmodule

`default_nettype wire

// ==== src/cpu_read_mux.sv ====
// ------------------------------
// Registered read data of both CPUs
// CPU A input ports follow the game code
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux (
    input  logic                           clk,
    input  logic                           RESETn,
    cpu_bus_if.sink                        cpu_a,
    cpu_bus_if.sink                        cpu_b,
    map_sel_if.reader                      sel,
    input  logic [2*ikari_pkg::BYTE_W-1:0] player1,
    input  logic [2*ikari_pkg::BYTE_W-1:0] player2,
    input  logic [7:0]                     game,
    input  logic [2*ikari_pkg::BYTE_W-1:0] dsw,
    input  logic                           snd_busy,
    input  logic [ikari_pkg::BYTE_W-1:0]   a_vid,
    input  logic [ikari_pkg::BYTE_W-1:0]   b_vid,
    output logic [ikari_pkg::BYTE_W-1:0]   a_din,
    output logic [ikari_pkg::BYTE_W-1:0]   b_din
);

    ikari_pkg::sys_port_t sys_port;
    logic                 service;
    logic                 rambo;
    logic                 btn_game;    // Button port populated
    logic [7:0]           btn_byte;

    // Rambo 3 doubles the directions and others put the rotary on top
    function automatic logic [7:0] joy_byte(input logic [15:0] p, input logic r3);
        if (r3) begin
            return {p[ikari_pkg::BIT_LEFT], p[ikari_pkg::BIT_DOWN], p[ikari_pkg::BIT_UP],
                    p[ikari_pkg::BIT_RIGHT], p[ikari_pkg::BIT_RIGHT], p[ikari_pkg::BIT_LEFT],
                    p[ikari_pkg::BIT_DOWN], p[ikari_pkg::BIT_UP]};
        end
        return {p[ikari_pkg::BIT_ROT +: 4], p[ikari_pkg::BIT_RIGHT], p[ikari_pkg::BIT_LEFT],
                p[ikari_pkg::BIT_DOWN], p[ikari_pkg::BIT_UP]};
    endfunction

    assign service  = player1[ikari_pkg::BIT_SERVICE] & player2[ikari_pkg::BIT_SERVICE];
    assign rambo    = game == ikari_pkg::GAME_RAMBO3;
    assign btn_game = game inside {ikari_pkg::GAME_BTN_A, ikari_pkg::GAME_BTN_B,
                                   ikari_pkg::GAME_BTN_C, ikari_pkg::GAME_BTN_D};
    assign btn_byte = {3'b111, player2[ikari_pkg::BIT_BTN2], player2[ikari_pkg::BIT_BTN1],
                       1'b1, player1[ikari_pkg::BIT_BTN2], player1[ikari_pkg::BIT_BTN1]};

    // JP board orders the system port bits differently
    always_comb begin
        if (game == ikari_pkg::GAME_IKARIA) begin
            sys_port.ikari_jp = '{test: 1'b1, unused: 1'b1, snd_busy: snd_busy,
                start2: player2[ikari_pkg::BIT_START], start1: player1[ikari_pkg::BIT_START],
                service: service, coin2: player2[ikari_pkg::BIT_COIN],
                coin1: player1[ikari_pkg::BIT_COIN]};
        end else begin
            sys_port.standard = '{start1: player1[ikari_pkg::BIT_START],
                start2: player2[ikari_pkg::BIT_START], coin1: player1[ikari_pkg::BIT_COIN],
                coin2: player2[ikari_pkg::BIT_COIN], unused: 2'b11, service: service,
                snd_busy: snd_busy};
        end
    end

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            a_din <= ikari_pkg::IDLE_BYTE;
            b_din <= ikari_pkg::IDLE_BYTE;
        end else begin
            // CPU A in priority order of the I/O page
            if (!sel.port_sel_n[ikari_pkg::PORT_COIN])
                a_din <= sys_port;
            else if (!sel.port_sel_n[ikari_pkg::PORT_P1])
                a_din <= joy_byte(player1, rambo);
            else if (!sel.port_sel_n[ikari_pkg::PORT_P2])
                a_din <= joy_byte(player2, rambo);
            else if (!sel.port_sel_n[ikari_pkg::PORT_BTN] && btn_game)
                a_din <= btn_byte;
            else if (!sel.port_sel_n[ikari_pkg::PORT_DIP1])
                a_din <= dsw[7:0];
            else if (!sel.port_sel_n[ikari_pkg::PORT_DIP2])
                a_din <= dsw[15:8];
            else if (!sel.port_sel_n[ikari_pkg::PORT_NMI])
                a_din <= 8'hFF;
            else if (!sel.vid_a_n && !cpu_a.rd_n)
                a_din <= a_vid;
            else
                a_din <= ikari_pkg::IDLE_BYTE;

            // CPU B control port reads the idle byte
            if (!sel.vid_b_n && !cpu_b.rd_n)
                b_din <= b_vid;
            else
                b_din <= ikari_pkg::IDLE_BYTE;
        end
    end

endmodule

`default_nettype wire

// ==== src/video_data_path.sv ====
// ------------------------------
// Video data bus side of both CPUs
// Write mux toward the video bus, read latches back
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_data_path (
    input  logic                         clk,
    input  logic                         RESETn,
    cpu_bus_if.sink                      cpu_a,
    cpu_bus_if.sink                      cpu_b,
    map_sel_if.data                      sel,
    input  logic                         rla,
    input  logic                         rlb,
    input  logic                         wba,
    input  logic                         wbb,
    input  logic [ikari_pkg::BYTE_W-1:0] v_in,
    output logic [ikari_pkg::BYTE_W-1:0] cpua_d,
    output logic [ikari_pkg::BYTE_W-1:0] v_out,
    output logic [ikari_pkg::BYTE_W-1:0] a_vid,
    output logic [ikari_pkg::BYTE_W-1:0] b_vid
);

    logic [1:0]                  rl;       // Latch load, index 0 is CPU A
    logic [1:0]                  rd_win;   // CPU reading its window
    logic [ikari_pkg::BYTE_W-1:0] vlat [2];

    assign rl     = {rlb, rla};
    assign rd_win = {!sel.vid_b_n && !cpu_b.rd_n, !sel.vid_a_n && !cpu_a.rd_n};

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            cpua_d  <= ikari_pkg::IDLE_BYTE;
            vlat[0] <= '0;
            vlat[1] <= '0;
        end else begin
            cpua_d <= sel.acc_a_n ? ikari_pkg::IDLE_BYTE : cpu_a.dout;
            for (int i = 0; i < 2; i++) begin
                if (rl[i])          vlat[i] <= v_in;              // Transparent phase
                else if (!rd_win[i]) vlat[i] <= ikari_pkg::IDLE_BYTE;
            end
        end
    end

    assign a_vid = vlat[0];
    assign b_vid = vlat[1];

    // CPU A wins the video bus
    assign v_out = !wba ? cpua_d : (!wbb ? cpu_b.dout : ikari_pkg::IDLE_BYTE);

endmodule

`default_nettype wire

// ==== src/video_reg_decoder.sv ====
// ------------------------------
// Shared video address mux and register strobes
// Two 74138 style groups split by va[10]
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_reg_decoder (
    cpu_bus_if.sink                    cpu_a,
    cpu_bus_if.sink                    cpu_b,
    input  logic                       a_b,
    input  logic                       disc,
    input  logic                       vdg,
    output logic [ikari_pkg::VA_W-1:0] va,
    output logic                       b1sx, b1sy, bset, sset, f1sx, f1sy, f2sx, f2sy,
    output logic                       xset, yset, mset, f2ins, reg0, reg1
);

    logic       en;    // Both gates low
    logic [7:0] dec;   // One-hot of va[9:7]

    assign va = a_b ? cpu_b.addr[ikari_pkg::VA_W-1:0] : cpu_a.addr[ikari_pkg::VA_W-1:0];

    assign en  = !disc && !vdg;
    assign dec = 8'b1 << va[9:7];

    // C800-CB80, scroll and bank registers
    assign {f2sy, f2sx, f1sy, f1sx, sset, bset, b1sy, b1sx} = ~(dec & {8{en && !va[10]}});

    // CC00-CE80, top two outputs unused
    assign {reg1, reg0, f2ins, mset, yset, xset} = ~(dec[5:0] & {6{en && va[10]}});

endmodule

`default_nettype wire

// ==== src/ikari_cpu_glue.sv ====
// ------------------------------
// Bus glue between CPU A, CPU B and the shared video bus
// Plain ports in and out, interfaces only inside
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ikari_cpu_glue (
    input  logic                           clk,
    input  logic                           RESETn,
    // CPU A bus
    input  logic [ikari_pkg::ADDR_W-1:0]   a_addr,
    input  logic                           a_mreq_n, a_iorq_n, a_rd_n, a_wr_n,
    input  logic [ikari_pkg::BYTE_W-1:0]   a_dout,
    // CPU B bus
    input  logic [ikari_pkg::ADDR_W-1:0]   b_addr,
    input  logic                           b_mreq_n, b_iorq_n, b_rd_n, b_wr_n,
    input  logic [ikari_pkg::BYTE_W-1:0]   b_dout,
    // Players and switches
    input  logic [2*ikari_pkg::BYTE_W-1:0] player1, player2,
    input  logic [7:0]                     game,
    input  logic [2*ikari_pkg::BYTE_W-1:0] dsw,
    input  logic                           snd_busy,
    // Video control
    input  logic                           vbl, a_b, disc, vdg,
    input  logic                           rla, rlb, wba, wbb,
    input  logic [ikari_pkg::BYTE_W-1:0]   v_in,
    // CPU returns
    output logic [ikari_pkg::BYTE_W-1:0]   a_din, b_din,
    output logic                           a_nmi_n, b_nmi_n, a_int_n, b_int_n,
    output logic                           ae, be,
    output logic [ikari_pkg::BYTE_W-1:0]   cpua_d,
    // I/O strobes
    output logic                           coin, p1, p2, p1_p2, mcode, dip1, dip2,
    // Shared video bus
    output logic [ikari_pkg::VA_W-1:0]     va,
    output logic [ikari_pkg::BYTE_W-1:0]   v_out,
    output logic                           b1sx, b1sy, bset, sset, f1sx, f1sy, f2sx, f2sy,
    output logic                           xset, yset, mset, f2ins, reg0, reg1
);

    cpu_bus_if bus_a ();
    cpu_bus_if bus_b ();
    map_sel_if sel ();

    logic [ikari_pkg::BYTE_W-1:0] a_vid, b_vid;   // Latched video bytes

    // ------------------------------
    // CPU ports onto the bus bundles
    // ------------------------------
    assign bus_a.addr   = a_addr;
    assign bus_a.mreq_n = a_mreq_n;
    assign bus_a.iorq_n = a_iorq_n;
    assign bus_a.rd_n   = a_rd_n;
    assign bus_a.wr_n   = a_wr_n;
    assign bus_a.dout   = a_dout;

    assign bus_b.addr   = b_addr;
    assign bus_b.mreq_n = b_mreq_n;
    assign bus_b.iorq_n = b_iorq_n;
    assign bus_b.rd_n   = b_rd_n;
    assign bus_b.wr_n   = b_wr_n;
    assign bus_b.dout   = b_dout;

    // I/O page strobes straight out
    assign coin  = sel.port_sel_n[ikari_pkg::PORT_COIN];
    assign p1    = sel.port_sel_n[ikari_pkg::PORT_P1];
    assign p2    = sel.port_sel_n[ikari_pkg::PORT_P2];
    assign p1_p2 = sel.port_sel_n[ikari_pkg::PORT_BTN];
    assign mcode = sel.port_sel_n[ikari_pkg::PORT_MCODE];
    assign dip1  = sel.port_sel_n[ikari_pkg::PORT_DIP1];
    assign dip2  = sel.port_sel_n[ikari_pkg::PORT_DIP2];

    bus_decoder u_dec (
        .clk(clk), .cpu_a(bus_a), .cpu_b(bus_b), .sel(sel), .ae(ae), .be(be)
    );

    cpu_interrupts u_irq (
        .clk(clk), .RESETn(RESETn), .cpu_a(bus_a), .cpu_b(bus_b), .sel(sel), .vbl(vbl),
        .a_nmi_n(a_nmi_n), .b_nmi_n(b_nmi_n), .a_int_n(a_int_n), .b_int_n(b_int_n)
    );

    cpu_read_mux u_rdmux (
        .clk(clk), .RESETn(RESETn), .cpu_a(bus_a), .cpu_b(bus_b), .sel(sel),
        .player1(player1), .player2(player2), .game(game), .dsw(dsw),
        .snd_busy(snd_busy), .a_vid(a_vid), .b_vid(b_vid), .a_din(a_din), .b_din(b_din)
    );

    video_data_path u_vdata (
        .clk(clk), .RESETn(RESETn), .cpu_a(bus_a), .cpu_b(bus_b), .sel(sel),
        .rla(rla), .rlb(rlb), .wba(wba), .wbb(wbb), .v_in(v_in),
        .cpua_d(cpua_d), .v_out(v_out), .a_vid(a_vid), .b_vid(b_vid)
    );

    video_reg_decoder u_vreg (
        .cpu_a(bus_a), .cpu_b(bus_b), .a_b(a_b), .disc(disc), .vdg(vdg), .va(va),
        .b1sx(b1sx), .b1sy(b1sy), .bset(bset), .sset(sset),
        .f1sx(f1sx), .f1sy(f1sy), .f2sx(f2sx), .f2sy(f2sy),
        .xset(xset), .yset(yset), .mset(mset), .f2ins(f2ins), .reg0(reg0), .reg1(reg1)
    );

endmodule

`default_nettype wire

// ==== tests/tb_ikari_cpu_glue.sv ====
// ------------------------------
// Testbench for the dual Z80 bus glue
// Random vectors against a behavioral model, then directed
// NMI mailbox, VBL interrupt and video latch sequences
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ikari_cpu_glue;

    // Player word bits, active low
    localparam int P_COIN    = 0;
    localparam int P_START   = 1;
    localparam int P_BTN1    = 2;
    localparam int P_BTN2    = 3;
    localparam int P_ROT     = 4;   // Rotary nibble
    localparam int P_SERVICE = 9;
    localparam int P_LEFT    = 10;
    localparam int P_RIGHT   = 11;
    localparam int P_DOWN    = 12;
    localparam int P_UP      = 13;
    localparam int TIMEOUT   = 50;   // Cycles per wait
    localparam int VECTORS   = 400;

    logic        clk = 1'b0;
    logic        RESETn;
    logic [15:0] a_addr, b_addr, player1, player2, dsw;
    logic        a_mreq_n, a_iorq_n, a_rd_n, a_wr_n, b_mreq_n, b_iorq_n, b_rd_n, b_wr_n;
    logic [7:0]  a_dout, b_dout, game, v_in, a_din, b_din, cpua_d, v_out;
    logic        snd_busy, vbl, a_b, disc, vdg, rla, rlb, wba, wbb;
    logic        a_nmi_n, b_nmi_n, a_int_n, b_int_n, ae, be;
    logic        coin, p1, p2, p1_p2, mcode, dip1, dip2;
    logic [11:0] va;
    logic        b1sx, b1sy, bset, sset, f1sx, f1sy, f2sx, f2sy;
    logic        xset, yset, mset, f2ins, reg0, reg1;
    logic [31:0] lfsr;
    int          errors, checks;

    ikari_cpu_glue DUT (.*);

    always #10 clk = ~clk;   // 20 ns

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [4:0] page_pick();
        logic [31:0] r;
        r = rand_bits(7);
        case (r[1:0])
            2'd0:    return ikari_pkg::IO_PAGE;
            2'd1:    return ikari_pkg::VID_PAGE;
            2'd2:    return r[6:2];
            default: return {1'b0, r[5:2]};   // Program space, reads FF
        endcase
    endfunction

    function automatic logic [7:0] game_pick();
        logic [31:0] r;
        r = rand_bits(11);
        case (r[2:0])
            3'd0:    return ikari_pkg::GAME_IKARIA;
            3'd1:    return ikari_pkg::GAME_RAMBO3;
            3'd2:    return ikari_pkg::GAME_BTN_A;
            3'd3:    return ikari_pkg::GAME_BTN_C;
            3'd4:    return ikari_pkg::GAME_BTN_D;
            default: return r[10:3];
        endcase
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [7:0] sys_byte(input logic [7:0] g, input logic [15:0] q1,
                                            input logic [15:0] q2, input logic sb);
        ikari_pkg::sys_port_t s;
        logic                 svc;
        svc = q1[P_SERVICE] & q2[P_SERVICE];   // Either switch, low active
        if (g == ikari_pkg::GAME_IKARIA)
            s.ikari_jp = {2'b11, sb, q2[P_START], q1[P_START], svc, q2[P_COIN], q1[P_COIN]};
        else
            s.standard = {q1[P_START], q2[P_START], q1[P_COIN], q2[P_COIN], 2'b11, svc, sb};
        return s;
    endfunction

    function automatic logic [7:0] dir_byte(input logic [15:0] q, input logic r3);
        if (r3) begin   // Rambo 3, directions twice
            return {q[P_LEFT], q[P_DOWN], q[P_UP], q[P_RIGHT],
                    q[P_RIGHT], q[P_LEFT], q[P_DOWN], q[P_UP]};
        end
        return {q[P_ROT+3], q[P_ROT+2], q[P_ROT+1], q[P_ROT],
                q[P_RIGHT], q[P_LEFT], q[P_DOWN], q[P_UP]};
    endfunction

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic next_cycle(input int n);
        repeat (n) @(posedge clk);
        #2;   // Drive point after the edge
    endtask

    task automatic drive_a(input logic [15:0] ad, input logic mr, rd, wr, io);
        a_addr   = ad;
        a_mreq_n = mr;
        a_rd_n   = rd;
        a_wr_n   = wr;
        a_iorq_n = io;
    endtask

    task automatic drive_b(input logic [15:0] ad, input logic mr, rd, wr, io);
        b_addr   = ad;
        b_mreq_n = mr;
        b_rd_n   = rd;
        b_wr_n   = wr;
        b_iorq_n = io;
    endtask

    task automatic quiet_inputs;
        drive_a(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
        drive_b(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
        {vbl, a_b, rla, rlb} = 4'b0000;
        {disc, vdg, wba, wbb} = 4'b1111;
    endtask

    // Polls one of the four request outputs until it reaches the level
    task automatic wait_level(input logic [1:0] which, input logic level, input string what);
        logic [3:0] irq;
        int         n;
        n   = 0;
        irq = ~{4{level}};
        while (irq[which] !== level && n < TIMEOUT) begin
            next_cycle(1);
            n++;
            irq = {b_int_n, a_int_n, b_nmi_n, a_nmi_n};
        end
        if (irq[which] !== level) begin
            errors++;
            $display("Timeout: %s did not reach level %0d", what, level);
        end
    endtask

    // ------------------------------
    // Random vector, held 4 cycles
    // ------------------------------
    task automatic random_vector;
        logic [31:0] r;
        logic [7:0]  exp_a, exp_b, exp_cd, exp_out;
        logic [6:0]  exp_ports;
        logic [13:0] exp_stb;
        logic [11:0] exp_va;
        logic        a_io, a_win, b_win, btn_game;
        r = rand_bits(11);
        a_addr = {page_pick(), r[10:0]};
        r = rand_bits(11);
        b_addr = {page_pick(), r[10:0]};
        r = rand_bits(8);
        {a_mreq_n, a_iorq_n, a_rd_n, a_wr_n, b_mreq_n, b_iorq_n, b_rd_n, b_wr_n} = r[7:0];
        r = rand_bits(16);
        {a_dout, b_dout} = r[15:0];
        r = rand_bits(16);
        player1 = r[15:0];
        r = rand_bits(16);
        player2 = r[15:0];
        r = rand_bits(16);
        dsw = r[15:0];
        r = rand_bits(17);
        {snd_busy, vbl, a_b, disc, vdg, rla, rlb, wba, wbb} = r[8:0];
        v_in = r[16:9];
        game = game_pick();
        a_win = a_addr[15:11] == ikari_pkg::VID_PAGE;
        b_win = b_addr[15:11] == ikari_pkg::VID_PAGE;
        if (a_win && !a_rd_n) rla = 1'b1;   // Window reads see a fresh capture
        if (b_win && !b_rd_n) rlb = 1'b1;
        next_cycle(4);

        a_io      = !a_mreq_n && a_addr[15:11] == ikari_pkg::IO_PAGE;
        btn_game  = game == ikari_pkg::GAME_BTN_A || game == ikari_pkg::GAME_BTN_B ||
                    game == ikari_pkg::GAME_BTN_C || game == ikari_pkg::GAME_BTN_D;
        exp_ports = 7'h7F;
        exp_a     = 8'hFF;
        if (a_io) begin
            if (a_addr[10:8] != ikari_pkg::PORT_NMI) exp_ports[a_addr[10:8]] = 1'b0;
            case (a_addr[10:8])
                ikari_pkg::PORT_COIN: exp_a = sys_byte(game, player1, player2, snd_busy);
                ikari_pkg::PORT_P1:   exp_a = dir_byte(player1, game == ikari_pkg::GAME_RAMBO3);
                ikari_pkg::PORT_P2:   exp_a = dir_byte(player2, game == ikari_pkg::GAME_RAMBO3);
                ikari_pkg::PORT_BTN: if (btn_game)
                    exp_a = {3'b111, player2[P_BTN2], player2[P_BTN1], 1'b1,
                             player1[P_BTN2], player1[P_BTN1]};
                ikari_pkg::PORT_DIP1: exp_a = dsw[7:0];
                ikari_pkg::PORT_DIP2: exp_a = dsw[15:8];
                default:              exp_a = 8'hFF;   // MCODE and NMI control
            endcase
        end else if (a_win && !a_rd_n) begin
            exp_a = v_in;
        end
        exp_b   = (b_win && !b_rd_n) ? v_in : 8'hFF;
        exp_cd  = (a_addr[15:14] == 2'b11 && !a_mreq_n) ? a_dout : 8'hFF;
        exp_out = !wba ? exp_cd : (!wbb ? b_dout : 8'hFF);
        exp_va  = a_b ? b_addr[11:0] : a_addr[11:0];
        exp_stb = '1;
        if (!disc && !vdg) begin   // Low 8 first group, upper 6 second group
            if (!exp_va[10])
                exp_stb[{1'b0, exp_va[9:7]}] = 1'b0;
            else if (exp_va[9:7] < 3'd6)
                exp_stb[4'd8 + {1'b0, exp_va[9:7]}] = 1'b0;
        end

        compare("port strobes", 16'(exp_ports), 16'({dip2, dip1, mcode, p1_p2, p2, p1, coin}));
        compare("ae", 16'(a_win && !a_mreq_n), 16'(ae));
        compare("be", 16'(b_win && !b_mreq_n), 16'(be));
        compare("a_din", 16'(exp_a), 16'(a_din));
        compare("b_din", 16'(exp_b), 16'(b_din));
        compare("cpua_d", 16'(exp_cd), 16'(cpua_d));
        compare("v_out", 16'(exp_out), 16'(v_out));
        compare("va", 16'(exp_va), 16'(va));
        compare("video strobes", 16'(exp_stb), 16'({reg1, reg0, f2ins, mset, yset, xset,
                f2sy, f2sx, f1sy, f1sx, sset, bset, b1sy, b1sx}));
    endtask

    // ------------------------------
    // Directed sequences
    // ------------------------------
    task automatic nmi_mailbox;
        quiet_inputs();
        next_cycle(2);
        drive_a(16'hC700, 1'b0, 1'b1, 1'b0, 1'b1);   // Both acks clear old requests
        drive_b(16'hC000, 1'b0, 1'b1, 1'b0, 1'b1);
        next_cycle(1);
        quiet_inputs();
        next_cycle(2);
        compare("a_nmi_n cleared", 16'h1, 16'(a_nmi_n));
        compare("b_nmi_n cleared", 16'h1, 16'(b_nmi_n));
        drive_a(16'hC700, 1'b0, 1'b0, 1'b1, 1'b1);   // A reads C700
        next_cycle(2);
        compare("b_nmi_n during read", 16'h1, 16'(b_nmi_n));
        drive_a(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
        wait_level(2'd1, 1'b0, "b_nmi_n after CPU A read");
        next_cycle(4);
        compare("b_nmi_n held", 16'h0, 16'(b_nmi_n));
        drive_b(16'hC000, 1'b0, 1'b1, 1'b0, 1'b1);
        wait_level(2'd1, 1'b1, "b_nmi_n after CPU B write");
        drive_b(16'hC000, 1'b0, 1'b0, 1'b1, 1'b1);   // Mirror, B reads C000
        next_cycle(2);
        drive_b(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
        wait_level(2'd0, 1'b0, "a_nmi_n after CPU B read");
        next_cycle(4);
        compare("a_nmi_n held", 16'h0, 16'(a_nmi_n));
        drive_a(16'hC700, 1'b0, 1'b1, 1'b0, 1'b1);
        wait_level(2'd0, 1'b1, "a_nmi_n after CPU A write");
        quiet_inputs();
    endtask

    task automatic vbl_interrupts;
        drive_a(16'h0000, 1'b1, 1'b1, 1'b1, 1'b0);
        drive_b(16'h0000, 1'b1, 1'b1, 1'b1, 1'b0);
        next_cycle(1);
        quiet_inputs();
        next_cycle(1);
        compare("a_int_n idle", 16'h1, 16'(a_int_n));
        compare("b_int_n idle", 16'h1, 16'(b_int_n));
        vbl = 1'b1;
        wait_level(2'd2, 1'b0, "a_int_n after vbl");
        wait_level(2'd3, 1'b0, "b_int_n after vbl");
        a_iorq_n = 1'b0;   // Acknowledge on A only
        next_cycle(1);
        a_iorq_n = 1'b1;
        wait_level(2'd2, 1'b1, "a_int_n after CPU A iorq");
        compare("b_int_n kept", 16'h0, 16'(b_int_n));
        b_iorq_n = 1'b0;
        next_cycle(1);
        b_iorq_n = 1'b1;
        wait_level(2'd3, 1'b1, "b_int_n after CPU B iorq");
        vbl = 1'b0;
    endtask

    task automatic latch_readback;
        logic [31:0] r;
        drive_b(16'hC834, 1'b0, 1'b1, 1'b1, 1'b1);   // Window address settles
        next_cycle(2);
        r = rand_bits(8);
        b_rd_n = 1'b0;
        rlb    = 1'b1;
        v_in   = r[7:0];
        next_cycle(1);
        rlb  = 1'b0;
        v_in = ~r[7:0];   // Must not reach the CPU
        next_cycle(3);
        compare("b_din latched", 16'(r[7:0]), 16'(b_din));
        quiet_inputs();
    endtask

    initial begin
        lfsr   = 32'hab14_6efb;
        errors = 0;
        checks = 0;
        RESETn = 1'b0;
        quiet_inputs();
        {a_dout, b_dout, game, v_in} = '0;
        {player1, player2, dsw} = '1;
        snd_busy = 1'b1;
        next_cycle(10);
        compare("a_din reset", 16'hFF, 16'(a_din));
        compare("b_din reset", 16'hFF, 16'(b_din));
        compare("cpua_d reset", 16'hFF, 16'(cpua_d));
        compare("irq reset", 16'hF, 16'({a_nmi_n, b_nmi_n, a_int_n, b_int_n}));
        RESETn = 1'b1;
        for (int k = 0; k < VECTORS; k++) random_vector();
        nmi_mailbox();
        vbl_interrupts();
        latch_readback();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/ikari_pkg.sv
src/cpu_bus_if.sv
src/map_sel_if.sv
src/bus_decoder.sv
src/cpu_interrupts.sv
src/cpu_read_mux.sv
src/video_data_path.sv
src/video_reg_decoder.sv
src/ikari_cpu_glue.sv
tests/tb_ikari_cpu_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --top-module tb_ikari_cpu_glue -f build.f -Mdir obj_dir -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
